// File: src/io_pkg.sv
package io_pkg;

    // bus data word, also the counter width
    typedef logic [31:0] word_t;
    // offset inside the i/o window
    typedef logic [11:0] addr_t;
    // one uart character
    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  led_t;
    // carrier and modulator frequency control word
    typedef logic [23:0] fcw_t;
    typedef logic [4:0]  shift_t;

    // apb request from the master
    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        addr_t paddr;
        word_t pwdata;
    } apb_req_t;

    // apb response back to the master
    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // shared by the serializer and the deserializer
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_t;

    // register map
    localparam addr_t off_uart_stat = 12'h000;
    localparam addr_t off_uart_rx   = 12'h004;
    localparam addr_t off_uart_tx   = 12'h008;
    localparam addr_t off_cycles    = 12'h010;
    localparam addr_t off_insts     = 12'h014;
    localparam addr_t off_cnt_clr   = 12'h018;
    localparam addr_t off_empty     = 12'h020;
    localparam addr_t off_buttons   = 12'h024;
    localparam addr_t off_switches  = 12'h028;
    localparam addr_t off_leds      = 12'h030;
    localparam addr_t off_car_fcw   = 12'h100;
    localparam addr_t off_mod_fcw   = 12'h200;
    localparam addr_t off_mod_shift = 12'h204;
    localparam addr_t off_note_en   = 12'h208;
    localparam addr_t off_tx_en     = 12'h210;
    localparam addr_t off_tx_ack    = 12'h214;

endpackage

// File: src/apb_io_regs.sv
module apb_io_regs (
    input  logic             clk,
    input  logic             rst,
    input  io_pkg::apb_req_t req,
    input  logic [3:0]       buttons,
    input  logic [1:0]       switches,
    input  logic             empty,
    input  logic             tx_ack,
    input  logic             tx_ready,
    input  logic             rx_valid,
    input  io_pkg::byte_t    rx_data,
    input  io_pkg::word_t    cycles,
    input  io_pkg::word_t    insts,
    output io_pkg::apb_rsp_t rsp,
    output logic             cnt_clr,
    output logic             tx_start,
    output io_pkg::byte_t    tx_data,
    output logic             rx_pop,
    output logic             rd_en,
    output io_pkg::led_t     leds,
    output io_pkg::fcw_t     car_fcw,
    output io_pkg::fcw_t     mod_fcw,
    output io_pkg::shift_t   mod_shift,
    output logic             note_en,
    output logic             tx_en
);

    logic          access;
    logic          mapped;
    logic          tx_wait;
    logic          done;
    logic          wr;
    logic          rd;
    io_pkg::word_t rdata;

    // second cycle of a transfer
    assign access = req.psel && req.penable;

    // transmit write has to wait for an idle serializer
    assign tx_wait = req.pwrite && (req.paddr == io_pkg::off_uart_tx) && !tx_ready;
    assign done    = access && !tx_wait;

    // completing edge of a legal access
    assign wr = done && req.pwrite && mapped;
    assign rd = done && !req.pwrite && mapped;

    // address decode and read mux in one place
    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (req.paddr)
            io_pkg::off_uart_stat: rdata = {30'd0, rx_valid, tx_ready};
            io_pkg::off_uart_rx:   rdata = {24'd0, rx_data};
            // write only, reads as zero
            io_pkg::off_uart_tx,
            io_pkg::off_cnt_clr:   rdata = '0;
            io_pkg::off_cycles:    rdata = cycles;
            io_pkg::off_insts:     rdata = insts;
            io_pkg::off_empty:     rdata = {31'd0, empty};
            // button 3 is not wired to the map
            io_pkg::off_buttons:   rdata = {29'd0, buttons[2:0]};
            io_pkg::off_switches:  rdata = {30'd0, switches};
            io_pkg::off_tx_ack:    rdata = {31'd0, tx_ack};
            io_pkg::off_leds:      rdata = {26'd0, leds};
            io_pkg::off_car_fcw:   rdata = {8'd0, car_fcw};
            io_pkg::off_mod_fcw:   rdata = {8'd0, mod_fcw};
            io_pkg::off_mod_shift: rdata = {27'd0, mod_shift};
            io_pkg::off_note_en:   rdata = {31'd0, note_en};
            io_pkg::off_tx_en:     rdata = {31'd0, tx_en};
            default:               mapped = 1'b0;
        endcase
    end

    // response, low outside an access phase
    always_comb begin
        rsp.prdata  = (access && !req.pwrite) ? rdata : '0;
        rsp.pready  = done;
        rsp.pslverr = access && !mapped;
    end

    // fifo read strobe follows the button read itself
    assign rd_en = access && !req.pwrite && (req.paddr == io_pkg::off_buttons);

    // one-cycle action pulses
    assign cnt_clr  = wr && (req.paddr == io_pkg::off_cnt_clr);
    assign tx_start = wr && (req.paddr == io_pkg::off_uart_tx);
    assign tx_data  = req.pwdata[7:0];
    assign rx_pop   = rd && (req.paddr == io_pkg::off_uart_rx);

    // synth and led control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            leds      <= '0;
            car_fcw   <= '0;
            mod_fcw   <= '0;
            mod_shift <= '0;
            note_en   <= 1'b0;
            tx_en     <= 1'b0;
        end else if (wr) begin
            case (req.paddr)
                io_pkg::off_leds:      leds      <= req.pwdata[5:0];
                io_pkg::off_car_fcw:   car_fcw   <= req.pwdata[23:0];
                io_pkg::off_mod_fcw:   mod_fcw   <= req.pwdata[23:0];
                io_pkg::off_mod_shift: mod_shift <= req.pwdata[4:0];
                io_pkg::off_note_en:   note_en   <= req.pwdata[0];
                io_pkg::off_tx_en:     tx_en     <= req.pwdata[0];
                // status and action offsets hold no value here
                default: ;
            endcase
        end
    end

endmodule

// File: src/perf_counters.sv
module perf_counters (
    input  logic          clk,
    input  logic          rst,
    input  logic          cnt_clr,
    input  logic          inst_retired,
    output io_pkg::word_t cycles,
    output io_pkg::word_t insts
);

    // free running cycle count, wraps at 2^32
    always_ff @(posedge clk) begin
        if (rst) begin
            cycles <= '0;
        end else if (cnt_clr) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 32'd1;
        end
    end

    // retired instruction count
    always_ff @(posedge clk) begin
        if (rst) begin
            insts <= '0;
        end else if (cnt_clr) begin
            // a retire on the clearing edge is dropped
            insts <= '0;
        end else if (inst_retired) begin
            insts <= insts + 32'd1;
        end
    end

endmodule

// File: src/uart_tx.sv
module uart_tx #(
    parameter int clks_per_bit = 10
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          tx_start,
    input  io_pkg::byte_t tx_data,
    output logic          tx_ready,
    output logic          serial_out
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);

    io_pkg::uart_state_t state;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_idx;
    io_pkg::byte_t       shreg;
    logic                bit_end;

    // last cycle of the current bit period
    assign bit_end = (cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= io_pkg::st_idle;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            // bit timer runs in every state but idle
            if (state == io_pkg::st_idle || bit_end) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            case (state)
                io_pkg::st_idle: begin
                    if (tx_start) begin
                        state <= io_pkg::st_start;
                    end
                end
                io_pkg::st_start: begin
                    if (bit_end) begin
                        state   <= io_pkg::st_data;
                        bit_idx <= '0;
                    end
                end
                io_pkg::st_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        // eighth bit done
                        if (bit_idx == 3'd7) begin
                            state <= io_pkg::st_stop;
                        end
                    end
                end
                default: begin
                    // stop bit, ready again once it has run its full length
                    if (bit_end) begin
                        state <= io_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    // byte latch, shifted lsb first
    always_ff @(posedge clk) begin
        if (state == io_pkg::st_idle && tx_start) begin
            shreg <= tx_data;
        end else if (state == io_pkg::st_data && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    assign tx_ready = (state == io_pkg::st_idle);

    // line level from the frame position
    always_comb begin
        case (state)
            io_pkg::st_start: serial_out = 1'b0;
            io_pkg::st_data:  serial_out = shreg[0];
            default:          serial_out = 1'b1;
        endcase
    end

endmodule

// File: src/uart_rx.sv
module uart_rx #(
    parameter int clks_per_bit = 10
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          serial_in,
    input  logic          rx_pop,
    output logic          rx_valid,
    output io_pkg::byte_t rx_data
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    // half a bit, lands the samples near mid-bit
    localparam logic [cnt_w-1:0] mid_cnt = cnt_w'((clks_per_bit - 1) / 2);

    io_pkg::uart_state_t state;
    logic [cnt_w-1:0]    cnt;
    logic [2:0]          bit_idx;
    io_pkg::byte_t       shreg;
    logic                sync_0;
    logic                sync_1;
    logic                bit_end;
    logic                sample;
    logic                frame_ok;

    // two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b1;
            sync_1 <= 1'b1;
        end else begin
            sync_0 <= serial_in;
            sync_1 <= sync_0;
        end
    end

    assign bit_end  = (cnt == last_cnt);
    assign sample   = (state == io_pkg::st_data) && bit_end;
    // stop bit seen high at its middle
    assign frame_ok = (state == io_pkg::st_stop) && bit_end && sync_1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= io_pkg::st_idle;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                io_pkg::st_idle: begin
                    cnt <= '0;
                    // falling edge starts a frame
                    if (!sync_1) begin
                        state <= io_pkg::st_start;
                    end
                end
                io_pkg::st_start: begin
                    if (cnt == mid_cnt) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // a line back high at mid start bit was a glitch
                        state   <= sync_1 ? io_pkg::st_idle : io_pkg::st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                io_pkg::st_data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= io_pkg::st_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // back to idle at mid stop bit, ready for the next edge
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= io_pkg::st_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (sample) begin
            shreg <= {sync_1, shreg[7:1]};
        end
    end

    // holding register, a new frame overwrites an unread byte
    always_ff @(posedge clk) begin
        if (frame_ok) begin
            rx_data <= shreg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else if (frame_ok) begin
            rx_valid <= 1'b1;
        end else if (rx_pop) begin
            rx_valid <= 1'b0;
        end
    end

endmodule

// File: src/io_top.sv
module io_top #(
    parameter int clock_freq = 1_000_000,
    parameter int baud_rate  = 100_000
) (
    input  logic             clk,
    input  logic             rst,
    input  io_pkg::apb_req_t req,
    input  logic             serial_in,
    input  logic [3:0]       buttons,
    input  logic [1:0]       switches,
    input  logic             empty,
    input  logic             tx_ack,
    input  logic             inst_retired,
    output io_pkg::apb_rsp_t rsp,
    output logic             serial_out,
    output io_pkg::led_t     leds,
    output io_pkg::fcw_t     car_fcw,
    output io_pkg::fcw_t     mod_fcw,
    output io_pkg::shift_t   mod_shift,
    output logic             note_en,
    output logic             tx_en,
    output logic             rd_en
);

    // bit period in clocks, both uart halves share it
    localparam int clks_per_bit = clock_freq / baud_rate;

    logic          cnt_clr;
    logic          tx_start;
    io_pkg::byte_t tx_data;
    logic          tx_ready;
    logic          rx_pop;
    logic          rx_valid;
    io_pkg::byte_t rx_data;
    io_pkg::word_t cycles;
    io_pkg::word_t insts;

    // bus slave and register map
    apb_io_regs apb_io_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .buttons   (buttons),
        .switches  (switches),
        .empty     (empty),
        .tx_ack    (tx_ack),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .cycles    (cycles),
        .insts     (insts),
        .rsp       (rsp),
        .cnt_clr   (cnt_clr),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .rx_pop    (rx_pop),
        .rd_en     (rd_en),
        .leds      (leds),
        .car_fcw   (car_fcw),
        .mod_fcw   (mod_fcw),
        .mod_shift (mod_shift),
        .note_en   (note_en),
        .tx_en     (tx_en)
    );

    perf_counters perf_counters_inst (
        .clk          (clk),
        .rst          (rst),
        .cnt_clr      (cnt_clr),
        .inst_retired (inst_retired),
        .cycles       (cycles),
        .insts        (insts)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready),
        .serial_out (serial_out)
    );

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) uart_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_in),
        .rx_pop    (rx_pop),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data)
    );

endmodule

// File: tb/io_properties.sv
module io_properties (
    input logic             clk,
    input logic             rst,
    input io_pkg::apb_req_t req,
    input io_pkg::apb_rsp_t rsp,
    input logic             rd_en,
    input logic             serial_out,
    input logic             tx_ready,
    input logic             tx_start
);
    timeunit 1ns;
    timeprecision 1ps;

    // error response only on a completing edge
    slverr_with_ready: assert property (
        @(posedge clk) disable iff (rst) rsp.pslverr |-> rsp.pready
    ) else $error("pslverr raised without pready");

    // fifo strobe confined to the access phase
    rd_en_in_access: assert property (
        @(posedge clk) disable iff (rst) rd_en |-> (req.psel && req.penable)
    ) else $error("rd_en outside an access phase");

    // idle transmitter holds the line at the stop level
    line_idle_high: assert property (
        @(posedge clk) disable iff (rst) tx_ready |-> serial_out
    ) else $error("serial_out low while tx_ready is high");

    // no new frame while one is on the line
    start_when_ready: assert property (
        @(posedge clk) disable iff (rst) tx_start |-> tx_ready
    ) else $error("tx_start while the transmitter is busy");

endmodule

// File: tb/tb_io_top.sv
module tb_io_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clock_freq  = 1_000_000;
    localparam int baud_rate   = 100_000;
    localparam int bit_clks    = clock_freq / baud_rate;
    // longest stall is one frame
    localparam int apb_timeout = 20 * bit_clks;
    localparam int poll_limit  = 100;
    localparam int run_limit   = 100_000;

    logic             clk;
    logic             rst;
    io_pkg::apb_req_t req;
    io_pkg::apb_rsp_t rsp;
    logic             serial_line;
    logic [3:0]       buttons;
    logic [1:0]       switches;
    logic             empty;
    logic             tx_ack;
    logic             inst_retired;
    io_pkg::led_t     leds;
    io_pkg::fcw_t     car_fcw;
    io_pkg::fcw_t     mod_fcw;
    io_pkg::shift_t   mod_shift;
    logic             note_en;
    logic             tx_en;
    logic             rd_en;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    // edge index, read before the edge updates it
    int edge_cnt;
    int rd_en_edges;
    // filled in by each bus access
    int done_edge;
    int wait_cycles;

    // serial_out looped back into serial_in
    io_top #(
        .clock_freq (clock_freq),
        .baud_rate  (baud_rate)
    ) io_top_inst (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .serial_in    (serial_line),
        .buttons      (buttons),
        .switches     (switches),
        .empty        (empty),
        .tx_ack       (tx_ack),
        .inst_retired (inst_retired),
        .rsp          (rsp),
        .serial_out   (serial_line),
        .leds         (leds),
        .car_fcw      (car_fcw),
        .mod_fcw      (mod_fcw),
        .mod_shift    (mod_shift),
        .note_en      (note_en),
        .tx_en        (tx_en),
        .rd_en        (rd_en)
    );

    bind io_top io_properties io_properties_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp),
        .rd_en      (rd_en),
        .serial_out (serial_out),
        .tx_ready   (tx_ready),
        .tx_start   (tx_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // edge count and rd_en pulses seen on rising edges
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (rd_en) begin
            rd_en_edges <= rd_en_edges + 1;
        end
    end

    task automatic check_word(input string name, input io_pkg::word_t got,
                              input io_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input io_pkg::byte_t got,
                              input io_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fcw(input string name, input io_pkg::fcw_t got,
                             input io_pkg::fcw_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%06h, expected 0x%06h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // setup cycle, then access until pready, sampled on the rising edge
    task automatic bus_access(input logic write, input io_pkg::addr_t addr,
                              input io_pkg::word_t wdata, output io_pkg::word_t rdata,
                              output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(negedge clk);
        // still in the setup phase, no response yet
        check_bit("pready in setup phase", rsp.pready, 1'b0);
        check_bit("pslverr in setup phase", rsp.pslverr, 1'b0);
        req.penable = 1'b1;
        @(posedge clk);
        while (!rsp.pready && waits < apb_timeout) begin
            waits++;
            @(posedge clk);
        end
        if (!rsp.pready) begin
            $display("access to offset 0x%03h saw no pready within %0d cycles",
                     addr, apb_timeout);
            errors++;
        end
        // only a transmit write may stretch the access phase
        if (!(write && addr == io_pkg::off_uart_tx)) begin
            check_word("pready wait cycles", io_pkg::word_t'(waits), '0);
        end
        rdata       = rsp.prdata;
        err         = rsp.pslverr;
        done_edge   = edge_cnt;
        wait_cycles = waits;
        @(negedge clk);
        req = '0;
    endtask

    task automatic apb_write(input io_pkg::addr_t addr, input io_pkg::word_t data,
                             output logic err);
        io_pkg::word_t unused;
        bus_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input io_pkg::addr_t addr, output io_pkg::word_t data,
                            output logic err);
        bus_access(1'b0, addr, '0, data, err);
    endtask

    // poll uart status until a byte is held
    task automatic wait_rx_valid();
        io_pkg::word_t st;
        logic err;
        int polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < poll_limit) begin
            apb_read(io_pkg::off_uart_stat, st, err);
            polls++;
        end
        if (!st[1]) begin
            $display("rx_valid still clear after %0d status polls", poll_limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // random write, port shows the masked value, readback matches
    task automatic write_control(input string name, input io_pkg::addr_t addr,
                                 input int width);
        io_pkg::word_t val;
        io_pkg::word_t exp;
        io_pkg::word_t rd;
        logic err;
        val = $urandom();
        // second pass writes the complement so every bit changes
        for (int pass = 0; pass < 2; pass++) begin
            exp = val & ((32'd1 << width) - 32'd1);
            apb_write(addr, val, err);
            check_bit({name, " write pslverr"}, err, 1'b0);
            case (addr)
                io_pkg::off_car_fcw: check_fcw(name, car_fcw, exp[23:0]);
                io_pkg::off_mod_fcw: check_fcw(name, mod_fcw, exp[23:0]);
                io_pkg::off_note_en: check_bit(name, note_en, exp[0]);
                io_pkg::off_tx_en:   check_bit(name, tx_en, exp[0]);
                io_pkg::off_leds:    check_word(name, {26'd0, leds}, exp);
                default:             check_word(name, {27'd0, mod_shift}, exp);
            endcase
            apb_read(addr, rd, err);
            check_word({name, " readback"}, rd, exp);
            val = ~val;
        end
    endtask

    task automatic sweep_control_regs();
        int e0;
        e0 = errors;
        write_control("leds", io_pkg::off_leds, 6);
        write_control("car_fcw", io_pkg::off_car_fcw, 24);
        write_control("mod_fcw", io_pkg::off_mod_fcw, 24);
        write_control("mod_shift", io_pkg::off_mod_shift, 5);
        write_control("note_en", io_pkg::off_note_en, 1);
        write_control("tx_en", io_pkg::off_tx_en, 1);
        report_test("control_regs", e0);
    endtask

    task automatic read_status_inputs();
        io_pkg::word_t tmp;
        io_pkg::word_t rd;
        logic err;
        int n0;
        int e0;
        e0 = errors;
        for (int round = 0; round < 4; round++) begin
            tmp = $urandom();
            @(negedge clk);
            buttons  = tmp[3:0];
            switches = tmp[5:4];
            empty    = tmp[6];
            tx_ack   = tmp[7];
            n0 = rd_en_edges;
            apb_read(io_pkg::off_empty, rd, err);
            check_word("empty", rd, {31'd0, tmp[6]});
            apb_read(io_pkg::off_switches, rd, err);
            check_word("switches", rd, {30'd0, tmp[5:4]});
            apb_read(io_pkg::off_tx_ack, rd, err);
            check_word("tx_ack", rd, {31'd0, tmp[7]});
            check_word("rd_en pulses before button read", io_pkg::word_t'(rd_en_edges - n0), 0);
            // only bits 2..0 of the buttons are mapped
            apb_read(io_pkg::off_buttons, rd, err);
            check_word("buttons", rd, {29'd0, tmp[2:0]});
            check_word("rd_en pulses after button read", io_pkg::word_t'(rd_en_edges - n0), 1);
        end
        report_test("status_inputs", e0);
    endtask

    task automatic count_cycles_retires();
        io_pkg::word_t rd;
        logic err;
        int n;
        int clr_edge;
        int e0;
        e0 = errors;
        n = $urandom_range(20, 1);
        apb_write(io_pkg::off_cnt_clr, '0, err);
        clr_edge = done_edge;
        // one-cycle retire pulses with a gap between them
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            inst_retired = 1'b1;
            @(negedge clk);
            inst_retired = 1'b0;
        end
        apb_read(io_pkg::off_insts, rd, err);
        check_word("insts", rd, io_pkg::word_t'(n));
        apb_read(io_pkg::off_cycles, rd, err);
        // edges after the clear, up to the start of the access phase
        check_word("cycles", rd, io_pkg::word_t'(done_edge - clr_edge - 1));
        report_test("counters", e0);
    endtask

    task automatic loop_back_byte();
        io_pkg::word_t tmp;
        io_pkg::word_t rd;
        logic err;
        int e0;
        e0 = errors;
        tmp = $urandom();
        apb_write(io_pkg::off_uart_tx, {24'd0, tmp[7:0]}, err);
        // idle transmitter takes the byte without a stall
        check_word("tx write wait cycles", io_pkg::word_t'(wait_cycles), '0);
        wait_rx_valid();
        apb_read(io_pkg::off_uart_rx, rd, err);
        check_byte("rx_data", rd[7:0], tmp[7:0]);
        apb_read(io_pkg::off_uart_stat, rd, err);
        check_bit("rx_valid after pop", rd[1], 1'b0);
        report_test("uart_loopback", e0);
    endtask

    task automatic stall_second_write();
        io_pkg::word_t tmp;
        io_pkg::word_t rd;
        logic err;
        int e0;
        e0 = errors;
        tmp = $urandom();
        apb_write(io_pkg::off_uart_tx, {24'd0, tmp[7:0]}, err);
        apb_write(io_pkg::off_uart_tx, {24'd0, tmp[15:8]}, err);
        // a frame is ten bit periods, nearly all of it spent stalled
        checks++;
        if (wait_cycles < 8 * bit_clks) begin
            $display("second transmit write stalled only %0d cycles", wait_cycles);
            errors++;
        end
        wait_rx_valid();
        apb_read(io_pkg::off_uart_rx, rd, err);
        check_byte("first byte", rd[7:0], tmp[7:0]);
        wait_rx_valid();
        apb_read(io_pkg::off_uart_rx, rd, err);
        check_byte("second byte", rd[7:0], tmp[15:8]);
        report_test("back_pressure", e0);
    endtask

    task automatic access_unmapped();
        io_pkg::led_t   leds_0;
        io_pkg::fcw_t   car_0;
        io_pkg::fcw_t   mod_0;
        io_pkg::shift_t shift_0;
        logic           note_0;
        logic           tx_en_0;
        io_pkg::word_t  rd;
        logic           err;
        int             e0;
        e0      = errors;
        leds_0  = leds;
        car_0   = car_fcw;
        mod_0   = mod_fcw;
        shift_0 = mod_shift;
        note_0  = note_en;
        tx_en_0 = tx_en;
        apb_write(12'h300, $urandom(), err);
        check_bit("unmapped write pslverr", err, 1'b1);
        apb_read(12'h00c, rd, err);
        check_bit("unmapped read pslverr", err, 1'b1);
        check_word("unmapped read data", rd, '0);
        check_word("leds kept", {26'd0, leds}, {26'd0, leds_0});
        check_fcw("car_fcw kept", car_fcw, car_0);
        check_fcw("mod_fcw kept", mod_fcw, mod_0);
        check_word("mod_shift kept", {27'd0, mod_shift}, {27'd0, shift_0});
        check_bit("note_en kept", note_en, note_0);
        check_bit("tx_en kept", tx_en, tx_en_0);
        report_test("unmapped", e0);
    endtask

    // stops a run that never reaches the end
    initial begin
        repeat (run_limit) @(posedge clk);
        $display("simulation did not finish within %0d cycles", run_limit);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h53fa_acd4));
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        edge_cnt     = 0;
        rd_en_edges  = 0;
        done_edge    = 0;
        wait_cycles  = 0;
        req          = '0;
        rst          = 1'b1;
        buttons      = '0;
        switches     = '0;
        empty        = 1'b0;
        tx_ack       = 1'b0;
        inst_retired = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        sweep_control_regs();
        read_status_inputs();
        count_cycles_retires();
        loop_back_byte();
        stall_second_write();
        access_unmapped();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
src/io_pkg.sv
src/apb_io_regs.sv
src/perf_counters.sv
src/uart_tx.sv
src/uart_rx.sv
src/io_top.sv
tb/io_properties.sv
tb/tb_io_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
